// File: design/conv2_coef_rom.sv
`timescale 1ns/1ps
`default_nettype none

module conv2_coef_rom (
    output stage2_cnn_pkg::coef_t o_coef
);

    import stage2_cnn_pkg::*;

    // ======================================================================
    // weight and bias tables, one set per output channel
    // ======================================================================
    generate
        for (genvar co = 0; co < ST2_CO; co++) begin : g_co
            assign o_coef.bias[co] = bias_rule(co);

            for (genvar ci = 0; ci < ST2_CI; ci++) begin : g_ci
                for (genvar ky = 0; ky < KY; ky++) begin : g_ky
                    for (genvar kx = 0; kx < KX; kx++) begin : g_kx
                        // folded to a constant at elaboration
                        assign o_coef.weight[co].w[ci][ky][kx] = weight_rule(co, ci, ky, kx);
                    end
                end
            end
        end
    endgenerate

endmodule

`default_nettype wire

// File: design/stage2_cnn_core.sv
`timescale 1ns/1ps
`default_nettype none

module stage2_cnn_core (
    input  logic                         clk,
    input  logic                         reset_n,
    input  logic                         i_in_valid,    // window valid
    input  stage2_cnn_pkg::window_t      i_window,
    input  stage2_cnn_pkg::coef_t        i_coef,
    output logic                         o_ot_valid,
    output stage2_cnn_pkg::ofmap_point_t o_ot_fmap
);

    import stage2_cnn_pkg::*;

    // ======================================================================
    // valid pipe, matched to the two lane stages
    // ======================================================================
    logic mul_valid;    // products in lane registers
    logic sum_valid;    // results in lane registers

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            mul_valid <= 1'b0;
            sum_valid <= 1'b0;
        end else begin
            mul_valid <= i_in_valid;
            sum_valid <= mul_valid;
        end
    end

    assign o_ot_valid = sum_valid;

    // ======================================================================
    // one lane per output channel
    // ======================================================================
    generate
        for (genvar co = 0; co < ST2_CO; co++) begin : g_lane
            stage2_mac_tree u_mac_tree (
                .clk      (clk),
                .reset_n  (reset_n),
                .i_en_mul (i_in_valid),
                .i_en_sum (mul_valid),
                .i_window (i_window),           // shared by all lanes
                .i_weight (i_coef.weight[co]),
                .i_bias   (i_coef.bias[co]),
                .o_result (o_ot_fmap.ch[co])
            );
        end
    endgenerate

endmodule

`default_nettype wire

// File: design/stage2_cnn_pkg.sv
`default_nettype none

package stage2_cnn_pkg;

    // ======================================================================
    // frame and datapath sizes
    // ======================================================================
    localparam int ST2_CI  = 3;     // input channels
    localparam int ST2_CO  = 3;     // output channels
    localparam int KX      = 3;
    localparam int KY      = 3;
    localparam int IMG_W   = 8;
    localparam int IMG_H   = 8;
    localparam int IBW     = 8;     // signed input sample
    localparam int W_BW    = 8;     // signed weight
    localparam int B_BW    = 16;    // signed bias
    localparam int ACC_BW  = 24;    // accumulator
    localparam int O_F_BW  = 13;    // signed result, sign bit dropped after relu

    localparam int COL_BW  = $clog2(IMG_W);
    localparam int ROW_BW  = $clog2(IMG_H);
    localparam int RES_MAX = (1 << (O_F_BW - 1)) - 1;  // 4095

    typedef logic signed [IBW-1:0]    sample_t;
    typedef logic signed [W_BW-1:0]   weight_t;
    typedef logic signed [B_BW-1:0]   bias_t;
    typedef logic [O_F_BW-2:0]        result_t;

    typedef struct packed {
        sample_t [ST2_CI-1:0] ch;
    } fmap_point_t;

    // pt[ky][kx], [0][0] is top-left
    typedef struct packed {
        fmap_point_t [KY-1:0][KX-1:0] pt;
    } window_t;

    typedef struct packed {
        weight_t [ST2_CI-1:0][KY-1:0][KX-1:0] w;
    } weight_set_t;

    typedef struct packed {
        weight_set_t [ST2_CO-1:0] weight;
        bias_t       [ST2_CO-1:0] bias;
    } coef_t;

    typedef struct packed {
        result_t [ST2_CO-1:0] ch;
    } ofmap_point_t;

    // weights cycle through -3..+3
    function automatic weight_t weight_rule(input int co, input int ci, input int ky,
                                            input int kx);
        return weight_t'(((co * ST2_CI * KY * KX + ci * KY * KX + ky * KX + kx) % 7) - 3);
    endfunction

    function automatic bias_t bias_rule(input int co);
        return bias_t'(co * 40 - 40);   // -40, 0, +40
    endfunction

endpackage

`default_nettype wire

// File: design/stage2_conv.sv
`timescale 1ns/1ps
`default_nettype none

module stage2_conv (
    input  logic                         clk,
    input  logic                         reset_n,
    input  logic                         i_in_valid,
    input  stage2_cnn_pkg::fmap_point_t  i_in_fmap,     // one point, all input channels
    output logic                         o_ot_valid,
    output stage2_cnn_pkg::ofmap_point_t o_ot_fmap      // one point, all output channels
);

    import stage2_cnn_pkg::*;

    // ======================================================================
    // window and coefficient paths
    // ======================================================================
    logic    win_valid;
    window_t window;
    coef_t   coef;

    stage2_line_buffer u_line_buffer (
        .clk         (clk),
        .reset_n     (reset_n),
        .i_in_valid  (i_in_valid),
        .i_in_fmap   (i_in_fmap),
        .o_win_valid (win_valid),
        .o_window    (window)
    );

    // constant tables, read by every lane
    conv2_coef_rom u_coef_rom (
        .o_coef (coef)
    );

    stage2_cnn_core u_cnn_core (
        .clk        (clk),
        .reset_n    (reset_n),
        .i_in_valid (win_valid),
        .i_window   (window),
        .i_coef     (coef),
        .o_ot_valid (o_ot_valid),
        .o_ot_fmap  (o_ot_fmap)
    );

endmodule

`default_nettype wire

// File: design/stage2_line_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module stage2_line_buffer (
    input  logic                        clk,
    input  logic                        reset_n,
    input  logic                        i_in_valid,
    input  stage2_cnn_pkg::fmap_point_t i_in_fmap,
    output logic                        o_win_valid,
    output stage2_cnn_pkg::window_t     o_window
);

    import stage2_cnn_pkg::*;

    // ======================================================================
    // raster position
    // ======================================================================
    logic [COL_BW-1:0] col_cnt;
    logic [ROW_BW-1:0] row_cnt;
    logic              last_col;
    logic              last_row;
    logic              win_hit;

    assign last_col = (col_cnt == COL_BW'(IMG_W - 1));
    assign last_row = (row_cnt == ROW_BW'(IMG_H - 1));
    assign win_hit  = (col_cnt >= COL_BW'(KX - 1)) && (row_cnt >= ROW_BW'(KY - 1));

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            col_cnt     <= '0;
            row_cnt     <= '0;
            o_win_valid <= 1'b0;
        end else begin
            o_win_valid <= i_in_valid && win_hit;
            if (i_in_valid) begin
                if (last_col) begin
                    col_cnt <= '0;
                    row_cnt <= last_row ? '0 : row_cnt + 1'b1;  // wrap into next frame
                end else begin
                    col_cnt <= col_cnt + 1'b1;
                end
            end
        end
    end

    // ======================================================================
    // row memories and window shift
    // ======================================================================
    fmap_point_t line_top [IMG_W];  // row r-2
    fmap_point_t line_mid [IMG_W];  // row r-1
    fmap_point_t new_col  [KY];

    // column entering on the right of the window
    assign new_col[0] = line_top[col_cnt];
    assign new_col[1] = line_mid[col_cnt];
    assign new_col[2] = i_in_fmap;

    always_ff @(posedge clk) begin
        if (i_in_valid) begin
            // each row moves up one line
            line_top[col_cnt] <= line_mid[col_cnt];
            line_mid[col_cnt] <= i_in_fmap;

            for (int ky = 0; ky < KY; ky++) begin
                for (int kx = 0; kx < KX - 1; kx++) begin
                    o_window.pt[ky][kx] <= o_window.pt[ky][kx+1];   // shift left
                end
                o_window.pt[ky][KX-1] <= new_col[ky];
            end
        end
    end

endmodule

`default_nettype wire

// File: design/stage2_mac_tree.sv
`timescale 1ns/1ps
`default_nettype none

module stage2_mac_tree (
    input  logic                        clk,
    input  logic                        reset_n,
    input  logic                        i_en_mul,
    input  logic                        i_en_sum,
    input  stage2_cnn_pkg::window_t     i_window,
    input  stage2_cnn_pkg::weight_set_t i_weight,
    input  stage2_cnn_pkg::bias_t       i_bias,
    output stage2_cnn_pkg::result_t     o_result
);

    import stage2_cnn_pkg::*;

    localparam int N_PROD = ST2_CI * KY * KX;           // 27 taps
    localparam int N_PAD  = 1 << $clog2(N_PROD);        // tree leaves

    typedef logic signed [IBW+W_BW-1:0] product_t;

    // ======================================================================
    // stage 1: products
    // ======================================================================
    product_t prod_q [N_PROD];

    always_ff @(posedge clk) begin
        if (i_en_mul) begin
            for (int ci = 0; ci < ST2_CI; ci++) begin
                for (int ky = 0; ky < KY; ky++) begin
                    for (int kx = 0; kx < KX; kx++) begin
                        prod_q[ci*KY*KX + ky*KX + kx] <=
                            i_window.pt[ky][kx].ch[ci] * i_weight.w[ci][ky][kx];
                    end
                end
            end
        end
    end

    // ======================================================================
    // stage 2: adder tree, bias, relu, saturation
    // ======================================================================
    logic signed [ACC_BW-1:0] sum_biased;

    always_comb begin
        logic signed [ACC_BW-1:0] node [N_PAD];
        for (int i = 0; i < N_PAD; i++) begin
            node[i] = '0;                               // unused leaves stay zero
        end
        for (int i = 0; i < N_PROD; i++) begin
            node[i] = ACC_BW'(prod_q[i]);               // sign extend
        end
        // pairwise levels, root ends in node[0]
        for (int step = 1; step < N_PAD; step = step * 2) begin
            for (int i = 0; i < N_PAD; i += 2 * step) begin
                node[i] = node[i] + node[i+step];
            end
        end
        sum_biased = node[0] + ACC_BW'(i_bias);
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            o_result <= '0;
        end else if (i_en_sum) begin
            if (sum_biased < 0) begin
                o_result <= '0;                         // relu
            end else if (sum_biased > ACC_BW'(RES_MAX)) begin
                o_result <= result_t'(RES_MAX);         // clip at 4095
            end else begin
                o_result <= sum_biased[O_F_BW-2:0];
            end
        end
    end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# build and run the stage2_conv testbench with Verilator
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_stage2_conv \
    -f stage2_conv.f \
    -o sim_tb_stage2_conv

./obj_dir/sim_tb_stage2_conv > "$LOG" 2>&1
cat "$LOG"

if grep -qx "ALL CHECKS PASSED" "$LOG"; then
    echo "simulation passed"
    exit 0
fi

echo "simulation failed, see $LOG"
exit 1

// File: stage2_conv.f
design/stage2_cnn_pkg.sv
design/stage2_line_buffer.sv
design/conv2_coef_rom.sv
design/stage2_mac_tree.sv
design/stage2_cnn_core.sv
design/stage2_conv.sv
verification/tb_clock_gen.sv
verification/tb_stage2_conv.sv

// File: verification/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS    = 40,
    parameter int RESET_CYCLES = 2
) (
    output logic o_clk,
    output logic o_reset_n
);

    initial begin
        o_clk = 1'b0;
        forever #(PERIOD_NS / 2) o_clk = ~o_clk;
    end

    initial begin
        o_reset_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge o_clk);
        #2 o_reset_n = 1'b1;    // release clear of the edge
    end

endmodule

`default_nettype wire

// File: verification/tb_stage2_conv.sv
`timescale 1ns/1ps
`default_nettype none

module tb_stage2_conv;

    import stage2_cnn_pkg::*;

    localparam int N_FRAMES       = 5;
    localparam int FRAME_OUTS     = (IMG_H - 2) * (IMG_W - 2);     // 36 windows
    localparam int TIMEOUT_CYCLES = N_FRAMES * IMG_W * IMG_H * 2 + 50;
    localparam int SAT_LIMIT      = 4095;
    localparam int FRAME_RANDOM   = 0;
    localparam int FRAME_HIGH     = 1;     // all +127, sums go negative
    localparam int FRAME_SAT      = 2;     // first window matches lane 0 signs

    logic         clk;
    logic         reset_n;
    logic         i_in_valid;
    fmap_point_t  i_in_fmap;
    logic         o_ot_valid;
    ofmap_point_t o_ot_fmap;

    logic         in_win;                  // driven point completes a window
    logic         exp_ready;
    ofmap_point_t exp_q [$];
    ofmap_point_t exp_cur;
    ofmap_point_t got_cur;
    fmap_point_t  frame_mem [IMG_H][IMG_W];
    logic [31:0]  lcg_state;
    int           cycle_cnt   = 0;
    int           out_cnt     = 0;
    int           sat_cnt     = 0;
    int           zero_cnt    = 0;
    int           data_errs   = 0;
    int           timing_errs = 0;
    int           other_errs  = 0;

    tb_clock_gen #(.PERIOD_NS(40), .RESET_CYCLES(2)) u_clock_gen (
        .o_clk     (clk),
        .o_reset_n (reset_n)
    );

    stage2_conv dut (
        .clk        (clk),
        .reset_n    (reset_n),
        .i_in_valid (i_in_valid),
        .i_in_fmap  (i_in_fmap),
        .o_ot_valid (o_ot_valid),
        .o_ot_fmap  (o_ot_fmap)
    );

    // ======================================================================
    // reference model
    // ======================================================================
    function automatic logic [7:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[23:16];
    endfunction

    function automatic int tap_weight(input int co, input int ci, input int ky, input int kx);
        return ((co * 27 + ci * 9 + ky * 3 + kx) % 7) - 3;
    endfunction

    function automatic int chan_bias(input int co);
        return co * 40 - 40;
    endfunction

    function automatic ofmap_point_t expected_point(input int r, input int c);
        ofmap_point_t res;
        int           acc;
        for (int co = 0; co < ST2_CO; co++) begin
            acc = chan_bias(co);
            for (int ci = 0; ci < ST2_CI; ci++) begin
                for (int ky = 0; ky < KY; ky++) begin
                    for (int kx = 0; kx < KX; kx++) begin
                        acc += $signed(frame_mem[r-2+ky][c-2+kx].ch[ci])
                               * tap_weight(co, ci, ky, kx);
                    end
                end
            end
            if (acc < 0) acc = 0;                   // relu
            else if (acc > SAT_LIMIT) acc = SAT_LIMIT;
            res.ch[co] = acc[O_F_BW-2:0];
        end
        return res;
    endfunction

    function automatic fmap_point_t make_point(input int kind, input int r, input int c);
        fmap_point_t pt;
        int          w;
        for (int ci = 0; ci < ST2_CI; ci++) begin
            case (kind)
                FRAME_HIGH: pt.ch[ci] = 8'h7f;
                FRAME_SAT: begin
                    w = (r < KY && c < KX) ? tap_weight(0, ci, r, c) : 0;
                    pt.ch[ci] = (w > 0) ? 8'h7f : ((w < 0) ? 8'h80 : 8'h00);
                end
                default: pt.ch[ci] = lcg_next();
            endcase
        end
        return pt;
    endfunction

    // ======================================================================
    // stimulus
    // ======================================================================
    task automatic send_point(input int r, input int c, input fmap_point_t pt);
        frame_mem[r][c] = pt;
        i_in_valid      = 1'b1;
        i_in_fmap       = pt;
        in_win          = (r >= KY - 1) && (c >= KX - 1);
        if (in_win) begin
            exp_q.push_back(expected_point(r, c));
            for (int co = 0; co < ST2_CO; co++) begin
                if (exp_q[$].ch[co] == 0) zero_cnt++;
                if (exp_q[$].ch[co] == SAT_LIMIT) sat_cnt++;
            end
        end
        @(posedge clk);
        #2;
    endtask

    task automatic idle_cycle();
        i_in_valid = 1'b0;
        in_win     = 1'b0;
        @(posedge clk);
        #2;
    endtask

    task automatic send_frame(input int kind, input bit gaps);
        for (int r = 0; r < IMG_H; r++) begin
            for (int c = 0; c < IMG_W; c++) begin
                if (gaps) begin
                    while (lcg_next() < 8'd96) idle_cycle();   // roughly 3 in 8 idle
                end
                send_point(r, c, make_point(kind, r, c));
            end
        end
    endtask

    // output capture, half a cycle before the assertions sample it
    always @(negedge clk) begin
        if (o_ot_valid) begin
            got_cur   = o_ot_fmap;
            exp_ready = (exp_q.size() != 0);
            if (exp_ready) exp_cur = exp_q.pop_front();
            out_cnt++;
        end
    end

    task automatic report_mismatch();
        if (!exp_ready) begin
            other_errs++;
            $display("output at %0t appeared with no expected point waiting", $time);
        end else begin
            for (int co = 0; co < ST2_CO; co++) begin
                if (got_cur.ch[co] != exp_cur.ch[co]) begin
                    data_errs++;
                    $display("CHECK FAILED at %0t: channel %0d got %0d expected %0d",
                             $time, co, got_cur.ch[co], exp_cur.ch[co]);
                end
            end
        end
    endtask

    // ======================================================================
    // assertions
    // ======================================================================
    a_reset_quiet: assert property (@(posedge clk)
        (!reset_n || !$past(reset_n)) |-> !o_ot_valid)
    else begin
        timing_errs++;
        $display("CHECK FAILED at %0t: o_ot_valid high in or just after reset", $time);
    end

    a_latency: assert property (@(posedge clk) disable iff (!reset_n)
        o_ot_valid == $past(i_in_valid && in_win, 3))
    else begin
        timing_errs++;
        $display("CHECK FAILED at %0t: o_ot_valid not 3 cycles after a completing point",
                 $time);
    end

    a_data: assert property (@(posedge clk) disable iff (!reset_n)
        o_ot_valid |-> (exp_ready && got_cur == exp_cur))
    else begin
        report_mismatch();
    end

    // ======================================================================
    // run control
    // ======================================================================
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    initial begin
        wait (cycle_cnt >= TIMEOUT_CYCLES);
        $display("timeout: run did not finish within %0d cycles, %0d outputs still expected",
                 TIMEOUT_CYCLES, exp_q.size());
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin
        int wait_cnt;
        i_in_valid = 1'b0;
        i_in_fmap  = '0;
        in_win     = 1'b0;
        exp_ready  = 1'b0;
        lcg_state  = 32'd46;
        @(posedge reset_n);
        @(posedge clk);
        #2;
        send_frame(FRAME_RANDOM, 1'b0);     // first frame, full rate
        send_frame(FRAME_HIGH, 1'b0);
        send_frame(FRAME_SAT, 1'b0);
        send_frame(FRAME_RANDOM, 1'b1);     // gaps in i_in_valid
        send_frame(FRAME_RANDOM, 1'b0);     // counters wrap between frames
        idle_cycle();
        wait_cnt = 0;
        while (exp_q.size() != 0 && wait_cnt < 20) begin
            idle_cycle();
            wait_cnt++;
        end
        repeat (5) idle_cycle();            // catch stray outputs
        if (exp_q.size() != 0) begin
            other_errs++;
            $display("run ended with %0d expected outputs never produced", exp_q.size());
        end
        if (out_cnt != N_FRAMES * FRAME_OUTS) begin
            other_errs++;
            $display("saw %0d outputs but %0d frames should give %0d",
                     out_cnt, N_FRAMES, N_FRAMES * FRAME_OUTS);
        end
        if (sat_cnt == 0 || zero_cnt == 0) begin
            other_errs++;
            $display("stimulus never reached saturation or the relu clamp");
        end
        $display("summary: %0d outputs, %0d data errors, %0d timing errors, %0d other errors",
                 out_cnt, data_errs, timing_errs, other_errs);
        if (data_errs + timing_errs + other_errs == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
